//--- hdl/cpuPkg.sv
package cpuPkg;

  // ####################
  // instruction word views.
  typedef struct packed {
    logic [4:0] opcode;
    logic [2:0] rs;
    logic [2:0] rt;
    logic [2:0] rd;
    logic [1:0] func;
  } rForm_t;

  typedef struct packed {
    logic [4:0] opcode;
    logic [2:0] rs;
    logic [2:0] rd;
    logic [4:0] imm5;
  } iForm_t;

  typedef union packed {
    rForm_t rForm;
    iForm_t iForm;
  } instrWord_t;

  // ####################
  localparam logic [4:0] opNop   = 5'b00001;
  localparam logic [4:0] opAddi  = 5'b01000;
  localparam logic [4:0] opSubi  = 5'b01001;
  localparam logic [4:0] opXori  = 5'b01010;
  localparam logic [4:0] opAndni = 5'b01011;
  localparam logic [4:0] opSlbi  = 5'b10010;
  localparam logic [4:0] opLbi   = 5'b11000;
  localparam logic [4:0] opAlu   = 5'b11011; // the R-form group, where func picks the operation.

  localparam logic [1:0] funcAdd  = 2'b00;
  localparam logic [1:0] funcSub  = 2'b01;
  localparam logic [1:0] funcXor  = 2'b10;
  localparam logic [1:0] funcAndn = 2'b11;

  localparam logic [15:0] nopWord = 16'h0800;

  // ####################
  typedef logic [1:0] aluOp_t;
  localparam aluOp_t aluAdd  = 2'd0;
  localparam aluOp_t aluXor  = 2'd1;
  localparam aluOp_t aluAndn = 2'd2; // the inversion itself comes from invB.
  localparam aluOp_t aluPass = 2'd3;

  // second ALU operand.
  localparam logic [2:0] seRt   = 3'd0;
  localparam logic [2:0] seS5   = 3'd1;
  localparam logic [2:0] seZ5   = 3'd2;
  localparam logic [2:0] seS8   = 3'd3;
  localparam logic [2:0] seSlbi = 3'd4;

  localparam logic [1:0] regDstRd  = 2'd0;
  localparam logic [1:0] regDstIRd = 2'd1;
  localparam logic [1:0] regDstRs  = 2'd2;

endpackage

//--- hdl/decodeUnit.sv
`timescale 1ns/1ps

module decodeUnit (
  input  logic [15:0]         instr,
  output logic [2:0]          rsNum,
  output logic [2:0]          rtNum,
  output logic [2:0]          rdNum,
  output logic                regWrite,
  output cpuPkg::aluOp_t      aluOp,
  output logic [2:0]          seSel,
  output logic                invA,
  output logic                invB,
  output logic                cin,
  output logic                readingRs,
  output logic                readingRt,
  output logic [15:0]         sExt5,
  output logic [15:0]         zExt5,
  output logic [15:0]         sExt8,
  output logic [15:0]         zExt8
);

  cpuPkg::instrWord_t word;
  logic [1:0] regDst;

  assign word  = instr;
  assign rsNum = word.rForm.rs;
  assign rtNum = word.rForm.rt;

  assign sExt5 = {{11{word.iForm.imm5[4]}}, word.iForm.imm5};
  assign zExt5 = {11'b0, word.iForm.imm5};
  assign sExt8 = {{8{instr[7]}}, instr[7:0]}; // imm8 is the low byte.
  assign zExt8 = {8'b0, instr[7:0]};

  always_comb begin
    regDst    = cpuPkg::regDstIRd;
    regWrite  = 1'b1;
    aluOp     = cpuPkg::aluAdd;
    seSel     = cpuPkg::seS5;
    invA      = 1'b0;
    invB      = 1'b0;
    cin       = 1'b0;
    readingRs = 1'b1;
    readingRt = 1'b0;
    case (word.rForm.opcode)
      cpuPkg::opAddi: begin
      end
      cpuPkg::opSubi: begin
        invA = 1'b1; // imm - rs.
        cin  = 1'b1;
      end
      cpuPkg::opXori: begin
        aluOp = cpuPkg::aluXor;
        seSel = cpuPkg::seZ5;
      end
      cpuPkg::opAndni: begin
        aluOp = cpuPkg::aluAndn;
        seSel = cpuPkg::seZ5;
        invB  = 1'b1;
      end
      cpuPkg::opLbi: begin
        regDst    = cpuPkg::regDstRs;
        aluOp     = cpuPkg::aluPass;
        seSel     = cpuPkg::seS8;
        readingRs = 1'b0;
      end
      cpuPkg::opSlbi: begin
        regDst = cpuPkg::regDstRs;
        aluOp  = cpuPkg::aluPass;
        seSel  = cpuPkg::seSlbi;
      end
      cpuPkg::opAlu: begin
        regDst    = cpuPkg::regDstRd;
        seSel     = cpuPkg::seRt;
        readingRt = 1'b1;
        case (word.rForm.func)
          cpuPkg::funcSub: begin
            invA = 1'b1; // rt - rs.
            cin  = 1'b1;
          end
          cpuPkg::funcXor:  aluOp = cpuPkg::aluXor;
          cpuPkg::funcAndn: begin
            aluOp = cpuPkg::aluAndn;
            invB  = 1'b1;
          end
          default: aluOp = cpuPkg::aluAdd;
        endcase
      end
      default: begin
        // NOP, and anything outside the subset, writes nothing.
        regWrite  = 1'b0;
        readingRs = 1'b0;
      end
    endcase
  end

  // the destination is resolved here, so only three bits travel on.
  always_comb begin
    case (regDst)
      cpuPkg::regDstRd: rdNum = word.rForm.rd;
      cpuPkg::regDstRs: rdNum = word.iForm.rs;
      default:          rdNum = word.iForm.rd;
    endcase
  end

endmodule

//--- hdl/regFile.sv
`timescale 1ns/1ps

module regFile (
  input  logic        clk,
  input  logic        rstN,
  input  logic [2:0]  rdAddrA,
  input  logic [2:0]  rdAddrB,
  output logic [15:0] rdDataA,
  output logic [15:0] rdDataB,
  input  logic        wrEn,
  input  logic [2:0]  wrAddr,
  input  logic [15:0] wrData
);

  logic [15:0] regs [8];

  // a write shows on the read ports only after the edge.
  always_ff @(posedge clk) begin
    if (!rstN) begin
      regs <= '{default: 16'h0000};
    end else if (wrEn) begin
      regs[wrAddr] <= wrData;
    end
  end

  assign rdDataA = regs[rdAddrA];
  assign rdDataB = regs[rdAddrB];

endmodule

//--- hdl/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
  input  logic [2:0] rsNum,
  input  logic [2:0] rtNum,
  input  logic       readingRs,
  input  logic       readingRt,
  input  logic       instrValid,
  input  logic       pendValid,
  input  logic       pendRegWrite,
  input  logic [2:0] pendDst,
  output logic       stall
);

  logic pending;
  logic rsHit;
  logic rtHit;

  // still stalls in the cycle the pending result is accepted.
  assign pending = pendValid && pendRegWrite;
  assign rsHit   = readingRs && (rsNum == pendDst);
  assign rtHit   = readingRt && (rtNum == pendDst);
  assign stall   = instrValid && pending && (rsHit || rtHit);

endmodule

//--- hdl/idExLatch.sv
`timescale 1ns/1ps

module idExLatch (
  input  logic           clk,
  input  logic           rstN,
  input  logic           instrValid,
  input  logic           stall,
  input  logic           resultReady,
  output logic           instrReady,
  input  logic [15:0]    instr,
  input  logic [15:0]    aIn,
  input  logic [15:0]    bIn,
  input  logic [2:0]     destIn,
  input  logic           regWrite,
  input  cpuPkg::aluOp_t aluOp,
  input  logic [2:0]     seSel,
  input  logic           invA,
  input  logic           invB,
  input  logic           cin,
  input  logic [15:0]    sExt5,
  input  logic [15:0]    zExt5,
  input  logic [15:0]    sExt8,
  input  logic [15:0]    zExt8,
  output logic [15:0]    aOut,
  output logic [15:0]    bOut,
  output logic [2:0]     destOut,
  output logic           regWriteOut,
  output cpuPkg::aluOp_t aluOpOut,
  output logic [2:0]     seSelOut,
  output logic           invAOut,
  output logic           invBOut,
  output logic           cinOut,
  output logic [15:0]    sExt5Out,
  output logic [15:0]    zExt5Out,
  output logic [15:0]    sExt8Out,
  output logic [15:0]    zExt8Out,
  output logic [15:0]    instrOut,
  output logic           validOut
);

  logic en;
  logic live; // low through reset so that instrReady stays down.
  logic take;

  assign en         = !validOut || resultReady; // empty, or emptied this edge.
  assign instrReady = en && !stall && live;
  assign take       = instrReady && instrValid;

  // ####################
  // control state takes a bubble on a stall or an idle input.
  always_ff @(posedge clk) begin
    if (!rstN) begin
      live        <= 1'b0;
      instrOut    <= cpuPkg::nopWord;
      regWriteOut <= 1'b0;
      validOut    <= 1'b0;
      destOut     <= 3'd0;
      aluOpOut    <= cpuPkg::aluAdd;
      seSelOut    <= cpuPkg::seRt;
      invAOut     <= 1'b0;
      invBOut     <= 1'b0;
      cinOut      <= 1'b0;
    end else begin
      live <= 1'b1;
      if (en) begin
        instrOut    <= take ? instr : cpuPkg::nopWord;
        regWriteOut <= take && regWrite;
        validOut    <= take && regWrite; // a NOP never reaches the result port.
        destOut     <= destIn;
        aluOpOut    <= aluOp;
        seSelOut    <= seSel;
        invAOut     <= invA;
        invBOut     <= invB;
        cinOut      <= cin;
      end
    end
  end

  // ####################
  always_ff @(posedge clk) begin
    if (en) begin
      aOut     <= aIn;
      bOut     <= bIn;
      sExt5Out <= sExt5;
      zExt5Out <= zExt5;
      sExt8Out <= sExt8;
      zExt8Out <= zExt8;
    end
  end

endmodule

//--- hdl/executeUnit.sv
`timescale 1ns/1ps

module executeUnit (
  input  logic [15:0]    aIn,
  input  logic [15:0]    bIn,
  input  cpuPkg::aluOp_t aluOp,
  input  logic [2:0]     seSel,
  input  logic           invA,
  input  logic           invB,
  input  logic           cin,
  input  logic [15:0]    sExt5,
  input  logic [15:0]    zExt5,
  input  logic [15:0]    sExt8,
  input  logic [15:0]    zExt8,
  output logic [15:0]    result
);

  logic [15:0] srcB;
  logic [15:0] opA;
  logic [15:0] opB;

  always_comb begin
    case (seSel)
      cpuPkg::seS5:   srcB = sExt5;
      cpuPkg::seZ5:   srcB = zExt5;
      cpuPkg::seS8:   srcB = sExt8;
      cpuPkg::seSlbi: srcB = {aIn[7:0], 8'h00} | zExt8; // rs << 8, then the byte.
      default:        srcB = bIn;
    endcase
  end

  assign opA = invA ? ~aIn : aIn;
  assign opB = invB ? ~srcB : srcB;

  // with invA and cin set the sum is opB minus rs.
  always_comb begin
    case (aluOp)
      cpuPkg::aluAdd:  result = opA + opB + {15'b0, cin};
      cpuPkg::aluXor:  result = opA ^ opB;
      cpuPkg::aluAndn: result = opA & opB;
      default:         result = opB;
    endcase
  end

endmodule

//--- hdl/decodeExecute.sv
`timescale 1ns/1ps

module decodeExecute (
  input  logic        clk,
  input  logic        rstN,
  input  logic [15:0] instr,
  input  logic        instrValid,
  output logic        instrReady,
  output logic        resultValid,
  input  logic        resultReady,
  output logic [2:0]  resultReg,
  output logic [15:0] resultData
);

  logic [2:0]     rsNum, rtNum, rdNum;
  logic           regWrite, invA, invB, cin, readingRs, readingRt;
  cpuPkg::aluOp_t aluOp;
  logic [2:0]     seSel;
  logic [15:0]    sExt5, zExt5, sExt8, zExt8;
  logic [15:0]    rdDataA, rdDataB;
  logic           stall;

  // execute side of the latch.
  logic [15:0]    exA, exB, exS5, exZ5, exS8, exZ8;
  logic           exRegWrite, exInvA, exInvB, exCin;
  cpuPkg::aluOp_t exAluOp;
  logic [2:0]     exSeSel;

  decodeUnit uDecode (
    .instr(instr), .rsNum(rsNum), .rtNum(rtNum), .rdNum(rdNum),
    .regWrite(regWrite), .aluOp(aluOp), .seSel(seSel),
    .invA(invA), .invB(invB), .cin(cin),
    .readingRs(readingRs), .readingRt(readingRt),
    .sExt5(sExt5), .zExt5(zExt5), .sExt8(sExt8), .zExt8(zExt8)
  );

  regFile uRegs (
    .clk(clk), .rstN(rstN),
    .rdAddrA(rsNum), .rdAddrB(rtNum), .rdDataA(rdDataA), .rdDataB(rdDataB),
    .wrEn(resultValid && resultReady), .wrAddr(resultReg), .wrData(resultData)
  );

  hazardUnit uHazard (
    .rsNum(rsNum), .rtNum(rtNum), .readingRs(readingRs), .readingRt(readingRt),
    .instrValid(instrValid), .pendValid(resultValid), .pendRegWrite(exRegWrite),
    .pendDst(resultReg), .stall(stall)
  );

  idExLatch uLatch (
    .clk(clk), .rstN(rstN), .instrValid(instrValid), .stall(stall),
    .resultReady(resultReady), .instrReady(instrReady), .instr(instr),
    .aIn(rdDataA), .bIn(rdDataB), .destIn(rdNum), .regWrite(regWrite),
    .aluOp(aluOp), .seSel(seSel), .invA(invA), .invB(invB), .cin(cin),
    .sExt5(sExt5), .zExt5(zExt5), .sExt8(sExt8), .zExt8(zExt8),
    .aOut(exA), .bOut(exB), .destOut(resultReg), .regWriteOut(exRegWrite),
    .aluOpOut(exAluOp), .seSelOut(exSeSel), .invAOut(exInvA), .invBOut(exInvB),
    .cinOut(exCin), .sExt5Out(exS5), .zExt5Out(exZ5), .sExt8Out(exS8),
    .zExt8Out(exZ8), .instrOut(), .validOut(resultValid)
  );

  executeUnit uExecute (
    .aIn(exA), .bIn(exB), .aluOp(exAluOp), .seSel(exSeSel),
    .invA(exInvA), .invB(exInvB), .cin(exCin),
    .sExt5(exS5), .zExt5(exZ5), .sExt8(exS8), .zExt8(exZ8),
    .result(resultData)
  );

endmodule

//--- bench/refModel.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// expected destination and value of one instruction run on its own.
// returns zero for an instruction that writes no register.
function automatic bit refResult(input logic [15:0] ins, input logic [15:0] rsVal,
                                 input logic [15:0] rtVal, output logic [2:0] dst,
                                 output logic [15:0] val);
  logic [15:0] s5;
  logic [15:0] z5;
  s5  = {{11{ins[4]}}, ins[4:0]};
  z5  = {11'b0, ins[4:0]};
  dst = ins[7:5]; // I-form destination.
  val = 16'h0000;
  refResult = 1'b1;
  case (ins[15:11])
    cpuPkg::opAlu: begin
      dst = ins[4:2];
      case (ins[1:0])
        cpuPkg::funcAdd: val = rsVal + rtVal;
        cpuPkg::funcSub: val = rtVal - rsVal; // subtraction runs rt minus rs.
        cpuPkg::funcXor: val = rsVal ^ rtVal;
        default:         val = rsVal & ~rtVal;
      endcase
    end
    cpuPkg::opAddi:  val = rsVal + s5;
    cpuPkg::opSubi:  val = s5 - rsVal;
    cpuPkg::opXori:  val = rsVal ^ z5;
    cpuPkg::opAndni: val = rsVal & ~z5;
    cpuPkg::opLbi: begin
      dst = ins[10:8];
      val = {{8{ins[7]}}, ins[7:0]};
    end
    cpuPkg::opSlbi: begin
      dst = ins[10:8];
      val = {rsVal[7:0], ins[7:0]};
    end
    default: refResult = 1'b0;
  endcase
endfunction

`endif

//--- bench/tbDecodeExecute.sv
`timescale 1ns/1ps

module tbDecodeExecute;

  localparam int chainLen      = 40;
  localparam int mixLen        = 400;
  localparam int numInstr      = 16 + chainLen + mixLen;
  localparam int timeoutCycles = 40 * numInstr;

  logic        clk;
  logic        rstN;
  logic [15:0] instr;
  logic        instrValid;
  logic        instrReady;
  logic        resultValid;
  logic        resultReady;
  logic [2:0]  resultReg;
  logic [15:0] resultData;

  logic [15:0] modelRegs [8];
  logic [18:0] expectQ [$];    // {destination, value} in program order.
  logic [15:0] instrList [$];
  logic [31:0] rngState;
  int          cycles;
  logic        holding;
  logic [2:0]  heldReg;
  logic [15:0] heldData;
  logic [18:0] head;

  decodeExecute DUT (
    .clk(clk), .rstN(rstN), .instr(instr), .instrValid(instrValid),
    .instrReady(instrReady), .resultValid(resultValid), .resultReady(resultReady),
    .resultReg(resultReg), .resultData(resultData)
  );

  `include "refModel.svh"

  function automatic logic [31:0] nextRand();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  // with chain set, the sources name the previous destination.
  function automatic logic [15:0] randomInstr(input bit chain, input logic [2:0] lastDst);
    logic [31:0] r;
    logic [2:0]  rs;
    logic [2:0]  rt;
    logic [3:0]  sel;
    r   = nextRand();
    rs  = chain ? lastDst : r[10:8];
    rt  = (chain && r[20]) ? lastDst : r[7:5];
    sel = r[19:16] % 4'd11;
    case (sel)
      4'd0, 4'd1, 4'd2, 4'd3: return {cpuPkg::opAlu, rs, rt, r[4:2], sel[1:0]};
      4'd4: return {cpuPkg::opAddi, rs, r[7:0]};
      4'd5: return {cpuPkg::opSubi, rs, r[7:0]};
      4'd6: return {cpuPkg::opXori, rs, r[7:0]};
      4'd7: return {cpuPkg::opAndni, rs, r[7:0]};
      4'd8: return {cpuPkg::opLbi, rs, r[7:0]};
      4'd9: return {cpuPkg::opSlbi, rs, r[7:0]};
      default: return {cpuPkg::opNop, r[10:0]};
    endcase
  endfunction

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "stopped at the first error");
  endtask

  // the model runs each instruction in the order it was accepted.
  task automatic acceptInstr(input logic [15:0] w);
    logic [2:0]  dst;
    logic [15:0] val;
    bit          writes;
    writes = refResult(w, modelRegs[w[10:8]], modelRegs[w[7:5]], dst, val);
    if (writes) begin
      modelRegs[dst] = val;
      expectQ.push_back({dst, val});
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= timeoutCycles) begin
      abortRun($sformatf("timeout: the run did not finish within %0d cycles", timeoutCycles));
    end
  end

  // ####################
  // response check.
  always @(posedge clk) begin
    if (rstN) begin
      assert (!$isunknown(resultValid)) else abortRun("resultValid is unknown after reset");
      if (holding) begin
        assert (resultValid === 1'b1)
          else abortRun("resultValid dropped before its result was accepted");
        assert (resultReg === heldReg)
          else abortRun($sformatf("Fail resultReg held %h now %h", heldReg, resultReg));
        assert (resultData === heldData)
          else abortRun($sformatf("Fail resultData held %h now %h", heldData, resultData));
      end
      if (resultValid === 1'b1 && resultReady === 1'b1) begin
        assert (expectQ.size() > 0)
          else abortRun("a result appeared that no accepted instruction produced");
        head = expectQ.pop_front();
        assert (resultReg === head[18:16])
          else abortRun($sformatf("Fail resultReg expected %h got %h", head[18:16], resultReg));
        assert (resultData === head[15:0])
          else abortRun($sformatf("Fail resultData expected %h got %h", head[15:0], resultData));
      end
      holding  = (resultValid === 1'b1) && (resultReady !== 1'b1);
      heldReg  = resultReg;
      heldData = resultData;
    end
  end

  // ####################
  // stimulus.
  initial begin
    logic [31:0] r;
    logic [2:0]  lastDst;
    logic [2:0]  dst;
    logic [15:0] val;
    int          pc;
    int          drain;
    bit          busy;
    rngState    = 32'h10f0_ffef;
    cycles      = 0;
    holding     = 1'b0;
    rstN        = 1'b0;
    instr       = cpuPkg::nopWord;
    instrValid  = 1'b0;
    resultReady = 1'b0;
    modelRegs   = '{default: 16'h0000};

    for (int i = 0; i < 8; i++) begin
      r = nextRand();
      instrList.push_back({cpuPkg::opLbi, 3'(i), r[7:0]});
    end
    for (int i = 0; i < 8; i++) begin
      instrList.push_back({cpuPkg::opAddi, 3'(i), 3'(i), 5'd0}); // read back through zero.
    end
    lastDst = 3'd0;
    for (int i = 0; i < chainLen; i++) begin
      instrList.push_back(randomInstr(1'b1, lastDst));
      if (refResult(instrList[$], 16'h0, 16'h0, dst, val)) begin
        lastDst = dst;
      end
    end
    for (int i = 0; i < mixLen; i++) begin
      instrList.push_back(randomInstr(1'b0, 3'd0));
    end

    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
      if (i > 0) begin
        assert (resultValid === 1'b0 && instrReady === 1'b0)
          else abortRun("a handshake output was high during reset");
      end
    end
    rstN <= 1'b1;

    pc   = 0;
    busy = 1'b0;
    while (pc < instrList.size() || busy) begin
      @(posedge clk);
      if (busy && instrReady === 1'b1) begin
        acceptInstr(instr);
        busy = 1'b0;
      end
      r = nextRand();
      resultReady <= (r[1:0] != 2'b00);
      if (!busy && pc < instrList.size() && r[4:2] != 3'd0) begin
        instr      <= instrList[pc];
        instrValid <= 1'b1;
        pc++;
        busy = 1'b1;
      end else if (!busy) begin
        instrValid <= 1'b0;
      end
    end

    drain = 0;
    while (expectQ.size() != 0 && drain < 50) begin
      @(posedge clk);
      resultReady <= 1'b1;
      drain++;
    end
    repeat (4) @(posedge clk);
    assert (expectQ.size() == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      abortRun($sformatf("%0d results were still outstanding at the end", expectQ.size()));
    end
  end

endmodule

//--- build.f
+incdir+bench
hdl/cpuPkg.sv
hdl/decodeUnit.sv
hdl/regFile.sv
hdl/hazardUnit.sv
hdl/idExLatch.sv
hdl/executeUnit.sv
hdl/decodeExecute.sv
bench/tbDecodeExecute.sv
